//--- source/io_subsys_pkg.sv
/*
  I/O subsystem shared definitions
  Bus and port widths, register block base address and offsets,
  AXI response codes and the enums used by the port state machine
  and the register decoder.
*/
`default_nettype none

package io_subsys_pkg;

  // ==========================================================================
  // Widths
  // ==========================================================================
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  // LED and switch count
  localparam int IO_W   = 8;

  // ==========================================================================
  // Register block placement
  // ==========================================================================
  localparam logic [ADDR_W-1:0] IO_BASE_ADDR = 32'hFFDC_0600;
  // 32 byte window, upper bits must match the base
  localparam int IO_REGION_BITS = 5;

  // Offsets inside the window
  localparam logic [IO_REGION_BITS-1:0] OFS_LED_DATA  = 5'h00;
  localparam logic [IO_REGION_BITS-1:0] OFS_LED_SET   = 5'h04;
  localparam logic [IO_REGION_BITS-1:0] OFS_LED_CLR   = 5'h08;
  localparam logic [IO_REGION_BITS-1:0] OFS_SW_STATE  = 5'h0C;
  localparam logic [IO_REGION_BITS-1:0] OFS_SW_CHANGE = 5'h10;

  // AXI response codes
  localparam logic [1:0] RESP_OKAY   = 2'd0;
  localparam logic [1:0] RESP_SLVERR = 2'd2;
  localparam logic [1:0] RESP_DECERR = 2'd3;

  // ==========================================================================
  // Enums
  // ==========================================================================
  // Slave port FSM, ST_WR_WAIT holds one of AW or W
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WR_WAIT,
    ST_WR_REQ,
    ST_RD_REQ,
    ST_B_RESP,
    ST_R_RESP
  } axil_state_t;

  // Decoded register select
  typedef enum logic [2:0] {
    SEL_NONE,
    SEL_LED_DATA,
    SEL_LED_SET,
    SEL_LED_CLR,
    SEL_SW_STATE,
    SEL_SW_CHANGE
  } reg_sel_t;

endpackage

`default_nettype wire

//--- source/axil_slave_port.sv
/*
  AXI4-Lite slave port
  Accepts write address and data in either order, or a read address,
  and issues one single-cycle internal request per transaction. The
  decoder answer is registered into the B or R channel and held until
  the master takes it. One transaction in flight at a time.
*/
`timescale 1ns/1ps
`default_nettype none

module axil_slave_port import io_subsys_pkg::*; (
  input  wire logic                clk25,
  input  wire logic                rst_i,
  // Write address channel
  input  wire logic                awvalid_i,
  output logic                     awready_o,
  input  wire logic [ADDR_W-1:0]   awaddr_i,
  // Write data channel
  input  wire logic                wvalid_i,
  output logic                     wready_o,
  input  wire logic [DATA_W-1:0]   wdata_i,
  input  wire logic [DATA_W/8-1:0] wstrb_i,
  // Write response channel
  output logic                     bvalid_o,
  input  wire logic                bready_i,
  output logic [1:0]               bresp_o,
  // Read address channel
  input  wire logic                arvalid_i,
  output logic                     arready_o,
  input  wire logic [ADDR_W-1:0]   araddr_i,
  // Read data channel
  output logic                     rvalid_o,
  input  wire logic                rready_i,
  output logic [DATA_W-1:0]        rdata_o,
  output logic [1:0]               rresp_o,
  // Internal request towards the decoder
  output logic                     req_valid_o,
  output logic                     req_write_o,
  output logic [ADDR_W-1:0]        req_addr_o,
  output logic [DATA_W-1:0]        req_wdata_o,
  output logic [DATA_W/8-1:0]      req_wstrb_o,
  // Combinational answer from the decoder
  input  wire logic [1:0]          resp_code_i,
  input  wire logic [DATA_W-1:0]   resp_rdata_i
);

  axil_state_t          state_q;
  axil_state_t          state_d;
  // Low through reset, high from the first cycle after it
  logic                 ready_en_q;
  logic                 aw_got_q;
  logic                 w_got_q;
  logic                 aw_fire;
  logic                 w_fire;
  logic                 ar_fire;
  logic                 aw_have;
  logic                 w_have;
  logic                 wr_phase;
  logic [ADDR_W-1:0]    addr_q;
  logic [DATA_W-1:0]    wdata_q;
  logic [DATA_W/8-1:0]  wstrb_q;
  logic [1:0]           bresp_q;
  logic [1:0]           rresp_q;
  logic [DATA_W-1:0]    rdata_q;

  // ==========================================================================
  // Handshakes
  // ==========================================================================
  // Write channels open while idle or waiting for the other half
  assign wr_phase  = ready_en_q && (state_q == ST_IDLE || state_q == ST_WR_WAIT);
  assign awready_o = wr_phase && !aw_got_q;
  assign wready_o  = wr_phase && !w_got_q;
  // Read only from idle and only with no write on the bus
  // so a write arriving with a read goes first
  assign arready_o = ready_en_q && (state_q == ST_IDLE) && !awvalid_i && !wvalid_i;

  assign aw_fire = awvalid_i && awready_o;
  assign w_fire  = wvalid_i && wready_o;
  assign ar_fire = arvalid_i && arready_o;

  // Halves captured so far, including this cycle
  assign aw_have = aw_got_q || aw_fire;
  assign w_have  = w_got_q || w_fire;

  // ==========================================================================
  // State machine
  // ==========================================================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE, ST_WR_WAIT: begin
        if (aw_have && w_have) begin
          state_d = ST_WR_REQ;
        end else if (aw_have || w_have) begin
          state_d = ST_WR_WAIT;
        end else if (ar_fire) begin
          state_d = ST_RD_REQ;
        end
      end
      // Request lasts exactly one cycle
      ST_WR_REQ: state_d = ST_B_RESP;
      ST_RD_REQ: state_d = ST_R_RESP;
      // Hold the response until the master takes it
      ST_B_RESP: begin
        if (bready_i) begin
          state_d = ST_IDLE;
        end
      end
      ST_R_RESP: begin
        if (rready_i) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk25) begin
    if (rst_i) begin
      state_q    <= ST_IDLE;
      ready_en_q <= 1'b0;
      aw_got_q   <= 1'b0;
      w_got_q    <= 1'b0;
    end else begin
      state_q    <= state_d;
      ready_en_q <= 1'b1;
      // Flags drop once the pair goes out as a request
      if (state_d == ST_WR_REQ) begin
        aw_got_q <= 1'b0;
        w_got_q  <= 1'b0;
      end else begin
        if (aw_fire) begin
          aw_got_q <= 1'b1;
        end
        if (w_fire) begin
          w_got_q <= 1'b1;
        end
      end
    end
  end

  // ==========================================================================
  // Payload capture
  // ==========================================================================
  always_ff @(posedge clk25) begin
    // AW and AR never transfer in the same cycle
    if (aw_fire) begin
      addr_q <= awaddr_i;
    end else if (ar_fire) begin
      addr_q <= araddr_i;
    end
    if (w_fire) begin
      wdata_q <= wdata_i;
      wstrb_q <= wstrb_i;
    end
    // Decoder answer sampled at the end of the request cycle
    if (state_q == ST_WR_REQ) begin
      bresp_q <= resp_code_i;
    end
    if (state_q == ST_RD_REQ) begin
      rdata_q <= resp_rdata_i;
      rresp_q <= resp_code_i;
    end
  end

  // Internal request
  assign req_valid_o = (state_q == ST_WR_REQ) || (state_q == ST_RD_REQ);
  assign req_write_o = (state_q == ST_WR_REQ);
  assign req_addr_o  = addr_q;
  assign req_wdata_o = wdata_q;
  assign req_wstrb_o = wstrb_q;

  // Response channels
  assign bvalid_o = (state_q == ST_B_RESP);
  assign bresp_o  = bresp_q;
  assign rvalid_o = (state_q == ST_R_RESP);
  assign rdata_o  = rdata_q;
  assign rresp_o  = rresp_q;

endmodule

`default_nettype wire

//--- source/io_reg_decoder.sv
/*
  I/O register decoder
  Maps the request address onto a register select, checks the access
  direction, drives the LED and switch strobes and forms the response
  code and read data in the same cycle as the request.
*/
`timescale 1ns/1ps
`default_nettype none

module io_reg_decoder import io_subsys_pkg::*; (
  input  wire logic                req_valid_i,
  input  wire logic                req_write_i,
  input  wire logic [ADDR_W-1:0]   req_addr_i,
  input  wire logic [DATA_W-1:0]   req_wdata_i,
  input  wire logic [DATA_W/8-1:0] req_wstrb_i,
  input  wire logic [IO_W-1:0]     led_value_i,
  input  wire logic [IO_W-1:0]     sw_state_i,
  input  wire logic [IO_W-1:0]     sw_change_i,
  output logic [1:0]               resp_code_o,
  output logic [DATA_W-1:0]        resp_rdata_o,
  output logic                     led_wr_o,
  output logic                     led_set_o,
  output logic                     led_clr_o,
  output logic [IO_W-1:0]          led_data_o,
  output logic                     sw_change_rd_o
);

  reg_sel_t  sel;
  logic      in_block;
  logic      allowed;
  logic      access_ok;
  logic      wr_en;
  logic [IO_W-1:0] rd_byte;

  // Upper address bits pick the block
  assign in_block = (req_addr_i[ADDR_W-1:IO_REGION_BITS] ==
                     IO_BASE_ADDR[ADDR_W-1:IO_REGION_BITS]);

  // Offset to register select, unused offsets stay SEL_NONE
  always_comb begin
    sel = SEL_NONE;
    if (in_block) begin
      case (req_addr_i[IO_REGION_BITS-1:0])
        OFS_LED_DATA:  sel = SEL_LED_DATA;
        OFS_LED_SET:   sel = SEL_LED_SET;
        OFS_LED_CLR:   sel = SEL_LED_CLR;
        OFS_SW_STATE:  sel = SEL_SW_STATE;
        OFS_SW_CHANGE: sel = SEL_SW_CHANGE;
        default:       sel = SEL_NONE;
      endcase
    end
  end

  // Direction check and read mux
  always_comb begin
    allowed = 1'b0;
    rd_byte = '0;
    case (sel)
      SEL_LED_DATA: begin
        allowed = 1'b1;
        rd_byte = led_value_i;
      end
      // Set and clear only take writes
      SEL_LED_SET, SEL_LED_CLR: allowed = req_write_i;
      SEL_SW_STATE: begin
        allowed = !req_write_i;
        rd_byte = sw_state_i;
      end
      SEL_SW_CHANGE: begin
        allowed = !req_write_i;
        rd_byte = sw_change_i;
      end
      default: allowed = 1'b0;
    endcase
  end

  // ==========================================================================
  // Response
  // ==========================================================================
  always_comb begin
    if (sel == SEL_NONE) begin
      resp_code_o = RESP_DECERR;
    end else if (!allowed) begin
      resp_code_o = RESP_SLVERR;
    end else begin
      resp_code_o = RESP_OKAY;
    end
  end

  // Zero-extended byte lane 0, data 0 for writes and errors
  assign resp_rdata_o = (!req_write_i && allowed) ? {{(DATA_W-IO_W){1'b0}}, rd_byte} : '0;

  // ==========================================================================
  // Strobes to the LED and switch port
  // ==========================================================================
  assign access_ok = req_valid_i && allowed;
  // Byte lane 0 must be enabled for any write effect
  assign wr_en     = access_ok && req_write_i && req_wstrb_i[0];

  assign led_wr_o       = wr_en && (sel == SEL_LED_DATA);
  assign led_set_o      = wr_en && (sel == SEL_LED_SET);
  assign led_clr_o      = wr_en && (sel == SEL_LED_CLR);
  assign led_data_o     = req_wdata_i[IO_W-1:0];
  assign sw_change_rd_o = access_ok && !req_write_i && (sel == SEL_SW_CHANGE);

endmodule

`default_nettype wire

//--- source/led_sw_port.sv
/*
  LED and switch port
  LED register with load, set and clear. Switches pass a two stage
  synchronizer and every bit change is kept in a sticky register
  that clears on read.
*/
`timescale 1ns/1ps
`default_nettype none

module led_sw_port import io_subsys_pkg::*; (
  input  wire logic            clk25,
  input  wire logic            rst_i,
  input  wire logic            led_wr_i,
  input  wire logic            led_set_i,
  input  wire logic            led_clr_i,
  input  wire logic [IO_W-1:0] led_data_i,
  input  wire logic            sw_change_rd_i,
  input  wire logic [IO_W-1:0] sw_i,
  output logic [IO_W-1:0]      led_o,
  output logic [IO_W-1:0]      sw_state_o,
  output logic [IO_W-1:0]      sw_change_o
);

  logic [IO_W-1:0] led_q;
  logic [IO_W-1:0] sw_meta_q;
  logic [IO_W-1:0] sw_sync_q;
  logic [IO_W-1:0] sw_change_q;
  logic [IO_W-1:0] sw_diff;

  // ==========================================================================
  // LED register
  // ==========================================================================
  // Decoder raises at most one strobe per request
  always_ff @(posedge clk25) begin
    if (rst_i) begin
      led_q <= '0;
    end else if (led_wr_i) begin
      led_q <= led_data_i;
    end else if (led_set_i) begin
      led_q <= led_q | led_data_i;
    end else if (led_clr_i) begin
      led_q <= led_q & ~led_data_i;
    end
  end

  // ==========================================================================
  // Switch synchronizer and change latch
  // ==========================================================================
  // Next synchronized sample against the current one
  assign sw_diff = sw_meta_q ^ sw_sync_q;

  always_ff @(posedge clk25) begin
    if (rst_i) begin
      sw_meta_q   <= '0;
      sw_sync_q   <= '0;
      sw_change_q <= '0;
    end else begin
      sw_meta_q <= sw_i;
      sw_sync_q <= sw_meta_q;
      // Read clears old bits, a change in the same cycle survives
      if (sw_change_rd_i) begin
        sw_change_q <= sw_diff;
      end else begin
        sw_change_q <= sw_change_q | sw_diff;
      end
    end
  end

  assign led_o       = led_q;
  assign sw_state_o  = sw_sync_q;
  // Value before the clear goes back on the read
  assign sw_change_o = sw_change_q;

endmodule

`default_nettype wire

//--- source/io_subsys_top.sv
/*
  I/O subsystem top level
  AXI4-Lite slave port, register decoder and LED/switch port.
*/
`timescale 1ns/1ps
`default_nettype none

module io_subsys_top import io_subsys_pkg::*; (
  input  wire logic                clk25,
  input  wire logic                rst_i,
  input  wire logic                awvalid_i,
  output logic                     awready_o,
  input  wire logic [ADDR_W-1:0]   awaddr_i,
  input  wire logic                wvalid_i,
  output logic                     wready_o,
  input  wire logic [DATA_W-1:0]   wdata_i,
  input  wire logic [DATA_W/8-1:0] wstrb_i,
  output logic                     bvalid_o,
  input  wire logic                bready_i,
  output logic [1:0]               bresp_o,
  input  wire logic                arvalid_i,
  output logic                     arready_o,
  input  wire logic [ADDR_W-1:0]   araddr_i,
  output logic                     rvalid_o,
  input  wire logic                rready_i,
  output logic [DATA_W-1:0]        rdata_o,
  output logic [1:0]               rresp_o,
  input  wire logic [IO_W-1:0]     sw_i,
  output logic [IO_W-1:0]          led_o
);

  // Request path
  logic                 req_valid;
  logic                 req_write;
  logic [ADDR_W-1:0]    req_addr;
  logic [DATA_W-1:0]    req_wdata;
  logic [DATA_W/8-1:0]  req_wstrb;
  logic [1:0]           resp_code;
  logic [DATA_W-1:0]    resp_rdata;
  // Decoder to LED/switch port
  logic                 led_wr;
  logic                 led_set;
  logic                 led_clr;
  logic [IO_W-1:0]      led_data;
  logic                 sw_change_rd;
  logic [IO_W-1:0]      sw_state;
  logic [IO_W-1:0]      sw_change;

  axil_slave_port i_axil_slave_port (
    .clk25        (clk25),
    .rst_i        (rst_i),
    .awvalid_i    (awvalid_i),
    .awready_o    (awready_o),
    .awaddr_i     (awaddr_i),
    .wvalid_i     (wvalid_i),
    .wready_o     (wready_o),
    .wdata_i      (wdata_i),
    .wstrb_i      (wstrb_i),
    .bvalid_o     (bvalid_o),
    .bready_i     (bready_i),
    .bresp_o      (bresp_o),
    .arvalid_i    (arvalid_i),
    .arready_o    (arready_o),
    .araddr_i     (araddr_i),
    .rvalid_o     (rvalid_o),
    .rready_i     (rready_i),
    .rdata_o      (rdata_o),
    .rresp_o      (rresp_o),
    .req_valid_o  (req_valid),
    .req_write_o  (req_write),
    .req_addr_o   (req_addr),
    .req_wdata_o  (req_wdata),
    .req_wstrb_o  (req_wstrb),
    .resp_code_i  (resp_code),
    .resp_rdata_i (resp_rdata)
  );

  io_reg_decoder i_io_reg_decoder (
    .req_valid_i    (req_valid),
    .req_write_i    (req_write),
    .req_addr_i     (req_addr),
    .req_wdata_i    (req_wdata),
    .req_wstrb_i    (req_wstrb),
    .led_value_i    (led_o),
    .sw_state_i     (sw_state),
    .sw_change_i    (sw_change),
    .resp_code_o    (resp_code),
    .resp_rdata_o   (resp_rdata),
    .led_wr_o       (led_wr),
    .led_set_o      (led_set),
    .led_clr_o      (led_clr),
    .led_data_o     (led_data),
    .sw_change_rd_o (sw_change_rd)
  );

  led_sw_port i_led_sw_port (
    .clk25          (clk25),
    .rst_i          (rst_i),
    .led_wr_i       (led_wr),
    .led_set_i      (led_set),
    .led_clr_i      (led_clr),
    .led_data_i     (led_data),
    .sw_change_rd_i (sw_change_rd),
    .sw_i           (sw_i),
    .led_o          (led_o),
    .sw_state_o     (sw_state),
    .sw_change_o    (sw_change)
  );

endmodule

`default_nettype wire

//--- tb/io_subsys_checker.sv
/*
  I/O subsystem checker
  Follows the AXI4-Lite transfers and the switch inputs, keeps a model
  of the LED register, the synchronized switches and the change bits,
  and compares every response and the LED outputs against it.
*/
`timescale 1ns/1ps
`default_nettype none

module io_subsys_checker import io_subsys_pkg::*; (
  input  wire logic              clk25,
  input  wire logic              rst_i,
  input  wire logic              awvalid_i,
  input  wire logic              awready_i,
  input  wire logic [ADDR_W-1:0] awaddr_i,
  input  wire logic              wvalid_i,
  input  wire logic              wready_i,
  input  wire logic [DATA_W-1:0] wdata_i,
  input  wire logic [3:0]        wstrb_i,
  input  wire logic              bvalid_i,
  input  wire logic              bready_i,
  input  wire logic [1:0]        bresp_i,
  input  wire logic              arvalid_i,
  input  wire logic              arready_i,
  input  wire logic [ADDR_W-1:0] araddr_i,
  input  wire logic              rvalid_i,
  input  wire logic              rready_i,
  input  wire logic [DATA_W-1:0] rdata_i,
  input  wire logic [1:0]        rresp_i,
  input  wire logic [IO_W-1:0]   sw_i,
  input  wire logic [IO_W-1:0]   led_i,
  // Expected response code of the running table entry
  input  wire logic [1:0]        exp_resp_i,
  output int                     check_cnt_o,
  output int                     err_cnt_o
);

  // Register model
  logic [IO_W-1:0]   led_m;
  logic [IO_W-1:0]   meta_m;
  logic [IO_W-1:0]   sync_m;
  logic [IO_W-1:0]   chg_m;
  logic [IO_W-1:0]   diff_m;
  // Transaction tracking
  logic              aw_got;
  logic              w_got;
  logic              wr_req;
  logic              rd_req;
  logic              b_pend;
  logic              r_pend;
  logic              clr_rd;
  logic [ADDR_W-1:0] wr_addr;
  logic [ADDR_W-1:0] rd_addr;
  logic [DATA_W-1:0] wr_data;
  logic [3:0]        wr_strb;
  logic [DATA_W-1:0] rdata_m;

  function automatic logic [ADDR_W-1:0] reg_addr(input logic [IO_REGION_BITS-1:0] ofs);
    return IO_BASE_ADDR | {{(ADDR_W-IO_REGION_BITS){1'b0}}, ofs};
  endfunction

  task automatic report_fail(input string msg);
    $display("Fail at %0d ns: %s", $time, msg);
    err_cnt_o++;
  endtask

  task automatic expect_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    check_cnt_o++;
    if (got !== exp) begin
      report_fail($sformatf("%s is %h, expected %h", what, got, exp));
    end
  endtask

  // ==========================================================================
  // Model update and compare, on values seen just before each edge
  // ==========================================================================
  always @(posedge clk25) begin
    if (rst_i) begin
      led_m       = '0;
      meta_m      = '0;
      sync_m      = '0;
      chg_m       = '0;
      aw_got      = 1'b0;
      w_got       = 1'b0;
      wr_req      = 1'b0;
      rd_req      = 1'b0;
      b_pend      = 1'b0;
      r_pend      = 1'b0;
      rdata_m     = '0;
      check_cnt_o = 0;
      err_cnt_o   = 0;
    end else begin
      expect_eq(32'(led_i), 32'(led_m), "led_o");
      // Valids low except while a response is owed
      expect_eq(32'(bvalid_i), 32'(b_pend), "bvalid_o");
      expect_eq(32'(rvalid_i), 32'(r_pend), "rvalid_o");
      if ((b_pend || r_pend) && (awready_i || wready_i || arready_i)) begin
        report_fail("a new transfer was offered while a response was still pending");
      end
      // Held responses are compared every cycle, so they must stay stable
      if (bvalid_i) begin
        expect_eq(32'(bresp_i), 32'(exp_resp_i), "bresp_o");
        if (bready_i) begin
          b_pend = 1'b0;
        end
      end
      if (rvalid_i) begin
        expect_eq(32'(rresp_i), 32'(exp_resp_i), "rresp_o");
        expect_eq(rdata_i, rdata_m, "rdata_o");
        if (rready_i) begin
          r_pend = 1'b0;
        end
      end

      // Request cycle, one edge after the last address or data transfer
      clr_rd = 1'b0;
      if (wr_req) begin
        // Byte lane 0 disabled means no effect
        if (wr_strb[0] && wr_addr == reg_addr(OFS_LED_DATA)) begin
          led_m = wr_data[IO_W-1:0];
        end else if (wr_strb[0] && wr_addr == reg_addr(OFS_LED_SET)) begin
          led_m = led_m | wr_data[IO_W-1:0];
        end else if (wr_strb[0] && wr_addr == reg_addr(OFS_LED_CLR)) begin
          led_m = led_m & ~wr_data[IO_W-1:0];
        end
        wr_req = 1'b0;
        b_pend = 1'b1;
      end
      if (rd_req) begin
        // Errors and write-only registers read as 0
        rdata_m = '0;
        if (rd_addr == reg_addr(OFS_LED_DATA)) begin
          rdata_m = 32'(led_m);
        end else if (rd_addr == reg_addr(OFS_SW_STATE)) begin
          rdata_m = 32'(sync_m);
        end else if (rd_addr == reg_addr(OFS_SW_CHANGE)) begin
          rdata_m = 32'(chg_m);
          clr_rd  = 1'b1;
        end
        rd_req = 1'b0;
        r_pend = 1'b1;
      end

      // Channel transfers at this edge
      if (awvalid_i && awready_i) begin
        aw_got  = 1'b1;
        wr_addr = awaddr_i;
      end
      if (wvalid_i && wready_i) begin
        w_got   = 1'b1;
        wr_data = wdata_i;
        wr_strb = wstrb_i;
      end
      if (aw_got && w_got) begin
        wr_req = 1'b1;
        aw_got = 1'b0;
        w_got  = 1'b0;
      end
      if (arvalid_i && arready_i) begin
        rd_req  = 1'b1;
        rd_addr = araddr_i;
      end

      // Two flop switch path, a change beside a clearing read survives
      diff_m = meta_m ^ sync_m;
      chg_m  = (clr_rd ? '0 : chg_m) | diff_m;
      sync_m = meta_m;
      meta_m = sw_i;
    end
  end

endmodule

`default_nettype wire

//--- tb/tb_io_subsys.sv
/*
  I/O subsystem testbench
  Applies a table of AXI4-Lite writes, reads and switch changes to the
  DUT with varied AW/W order and response back-pressure. The checker
  module compares responses and LED outputs against its model.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_io_subsys import io_subsys_pkg::*; ();

  localparam int N_ENTRIES  = 26;
  localparam int CLK_NS     = 40;
  // 40 cycles per entry plus the reset cycles
  localparam int TIMEOUT_NS = (N_ENTRIES * 40 + 5) * CLK_NS;

  typedef enum logic [1:0] {
    OP_WR,
    OP_RD,
    OP_SW
  } op_t;

  typedef struct packed {
    op_t         op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
    // 0 AW first, 1 W first, 2 together
    logic [1:0]  order;
    // Cycles with bready or rready held low
    logic [3:0]  dly;
    // Data replaced by the next LCG value
    logic        rnd;
    logic [1:0]  resp;
  } entry_t;

  entry_t      tbl [N_ENTRIES];
  int          n_ent;
  logic [31:0] lcg_state;
  int          checks;
  int          errors;

  logic               clk25;
  logic               rst;
  logic               awvalid;
  logic               awready;
  logic [ADDR_W-1:0]  awaddr;
  logic               wvalid;
  logic               wready;
  logic [DATA_W-1:0]  wdata;
  logic [3:0]         wstrb;
  logic               bvalid;
  logic               bready;
  logic [1:0]         bresp;
  logic               arvalid;
  logic               arready;
  logic [ADDR_W-1:0]  araddr;
  logic               rvalid;
  logic               rready;
  logic [DATA_W-1:0]  rdata;
  logic [1:0]         rresp;
  logic [IO_W-1:0]    sw;
  logic [IO_W-1:0]    led;
  logic [1:0]         exp_resp;

  initial clk25 = 1'b0;
  always #(CLK_NS / 2) clk25 = ~clk25;

  io_subsys_top i_io_subsys_top (
    .clk25     (clk25),
    .rst_i     (rst),
    .awvalid_i (awvalid),
    .awready_o (awready),
    .awaddr_i  (awaddr),
    .wvalid_i  (wvalid),
    .wready_o  (wready),
    .wdata_i   (wdata),
    .wstrb_i   (wstrb),
    .bvalid_o  (bvalid),
    .bready_i  (bready),
    .bresp_o   (bresp),
    .arvalid_i (arvalid),
    .arready_o (arready),
    .araddr_i  (araddr),
    .rvalid_o  (rvalid),
    .rready_i  (rready),
    .rdata_o   (rdata),
    .rresp_o   (rresp),
    .sw_i      (sw),
    .led_o     (led)
  );

  io_subsys_checker i_io_subsys_checker (
    .clk25       (clk25),
    .rst_i       (rst),
    .awvalid_i   (awvalid),
    .awready_i   (awready),
    .awaddr_i    (awaddr),
    .wvalid_i    (wvalid),
    .wready_i    (wready),
    .wdata_i     (wdata),
    .wstrb_i     (wstrb),
    .bvalid_i    (bvalid),
    .bready_i    (bready),
    .bresp_i     (bresp),
    .arvalid_i   (arvalid),
    .arready_i   (arready),
    .araddr_i    (araddr),
    .rvalid_i    (rvalid),
    .rready_i    (rready),
    .rdata_i     (rdata),
    .rresp_i     (rresp),
    .sw_i        (sw),
    .led_i       (led),
    .exp_resp_i  (exp_resp),
    .check_cnt_o (checks),
    .err_cnt_o   (errors)
  );

  // ==========================================================================
  // Helpers
  // ==========================================================================
  function automatic logic [31:0] reg_addr(input logic [IO_REGION_BITS-1:0] ofs);
    return IO_BASE_ADDR | {{(ADDR_W-IO_REGION_BITS){1'b0}}, ofs};
  endfunction

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic add_entry(input op_t op, input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input logic [1:0] order,
                           input logic [3:0] dly, input logic rnd, input logic [1:0] resp);
    tbl[n_ent] = '{op, addr, data, strb, order, dly, rnd, resp};
    n_ent++;
  endtask

  // Raise bready or rready after the delay and wait for the transfer
  task automatic take_response(input logic is_read, input logic [3:0] dly);
    repeat (dly) @(posedge clk25);
    if (is_read) begin
      rready <= 1'b1;
    end else begin
      bready <= 1'b1;
    end
    do begin
      @(posedge clk25);
    end while (!(is_read ? (rvalid && rready) : (bvalid && bready)));
    rready <= 1'b0;
    bready <= 1'b0;
  endtask

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input logic [1:0] order,
                           input logic [3:0] dly);
    logic aw_done;
    logic w_done;
    aw_done = 1'b0;
    w_done  = 1'b0;
    @(posedge clk25);
    awaddr <= addr;
    wdata  <= data;
    wstrb  <= strb;
    if (order != 2'd1) begin
      awvalid <= 1'b1;
    end
    if (order != 2'd0) begin
      wvalid <= 1'b1;
    end
    while (!(aw_done && w_done)) begin
      @(posedge clk25);
      if (awvalid && awready) begin
        awvalid <= 1'b0;
        aw_done = 1'b1;
      end
      if (wvalid && wready) begin
        wvalid <= 1'b0;
        w_done = 1'b1;
      end
      // Second channel opens once the first has transferred
      if (aw_done && !w_done && !wvalid) begin
        wvalid <= 1'b1;
      end
      if (w_done && !aw_done && !awvalid) begin
        awvalid <= 1'b1;
      end
    end
    take_response(1'b0, dly);
  endtask

  task automatic read_reg(input logic [31:0] addr, input logic [3:0] dly);
    @(posedge clk25);
    arvalid <= 1'b1;
    araddr  <= addr;
    do begin
      @(posedge clk25);
    end while (!(arvalid && arready));
    arvalid <= 1'b0;
    take_response(1'b1, dly);
  endtask

  // Hold long enough to pass the synchronizer
  task automatic set_switches(input logic [IO_W-1:0] value);
    @(posedge clk25);
    sw <= value;
    repeat (4) @(posedge clk25);
  endtask

  // ==========================================================================
  // Stimulus table
  // ==========================================================================
  task automatic fill_table();
    n_ent = 0;
    // Reset state
    add_entry(OP_RD, reg_addr(OFS_SW_CHANGE), 32'h0, 4'hF, 2'd0, 4'd0, 1'b0, RESP_OKAY);
    add_entry(OP_RD, reg_addr(OFS_LED_DATA), 32'h0, 4'hF, 2'd0, 4'd0, 1'b0, RESP_OKAY);
    // LED load, set, clear and a masked write
    add_entry(OP_WR, reg_addr(OFS_LED_DATA), 32'h0, 4'hF, 2'd0, 4'd0, 1'b1, RESP_OKAY);
    add_entry(OP_RD, reg_addr(OFS_LED_DATA), 32'h0, 4'hF, 2'd0, 4'd2, 1'b0, RESP_OKAY);
    add_entry(OP_WR, reg_addr(OFS_LED_SET), 32'h0F, 4'hF, 2'd1, 4'd3, 1'b0, RESP_OKAY);
    add_entry(OP_WR, reg_addr(OFS_LED_CLR), 32'h81, 4'hF, 2'd2, 4'd0, 1'b0, RESP_OKAY);
    add_entry(OP_RD, reg_addr(OFS_LED_DATA), 32'h0, 4'hF, 2'd0, 4'd5, 1'b0, RESP_OKAY);
    add_entry(OP_WR, reg_addr(OFS_LED_DATA), 32'hFF, 4'hE, 2'd2, 4'd0, 1'b0, RESP_OKAY);
    add_entry(OP_RD, reg_addr(OFS_LED_DATA), 32'h0, 4'hF, 2'd0, 4'd0, 1'b0, RESP_OKAY);
    // Switch state and sticky changes
    add_entry(OP_SW, 32'h0, 32'h0, 4'h0, 2'd0, 4'd0, 1'b1, RESP_OKAY);
    add_entry(OP_RD, reg_addr(OFS_SW_STATE), 32'h0, 4'hF, 2'd0, 4'd0, 1'b0, RESP_OKAY);
    add_entry(OP_SW, 32'h0, 32'h0, 4'h0, 2'd0, 4'd0, 1'b1, RESP_OKAY);
    add_entry(OP_SW, 32'h0, 32'h0, 4'h0, 2'd0, 4'd0, 1'b1, RESP_OKAY);
    add_entry(OP_RD, reg_addr(OFS_SW_CHANGE), 32'h0, 4'hF, 2'd0, 4'd1, 1'b0, RESP_OKAY);
    add_entry(OP_RD, reg_addr(OFS_SW_CHANGE), 32'h0, 4'hF, 2'd0, 4'd0, 1'b0, RESP_OKAY);
    // Decode and direction errors
    add_entry(OP_WR, IO_BASE_ADDR + 32'h20, 32'h55, 4'hF, 2'd0, 4'd0, 1'b0, RESP_DECERR);
    add_entry(OP_RD, 32'h0000_0600, 32'h0, 4'hF, 2'd0, 4'd0, 1'b0, RESP_DECERR);
    add_entry(OP_WR, reg_addr(5'h14), 32'hAA, 4'hF, 2'd1, 4'd0, 1'b0, RESP_DECERR);
    add_entry(OP_RD, reg_addr(5'h1C), 32'h0, 4'hF, 2'd0, 4'd0, 1'b0, RESP_DECERR);
    add_entry(OP_WR, reg_addr(OFS_SW_STATE), 32'hFF, 4'hF, 2'd2, 4'd4, 1'b0, RESP_SLVERR);
    add_entry(OP_RD, reg_addr(OFS_LED_SET), 32'h0, 4'hF, 2'd0, 4'd4, 1'b0, RESP_SLVERR);
    add_entry(OP_RD, reg_addr(OFS_LED_CLR), 32'h0, 4'hF, 2'd0, 4'd0, 1'b0, RESP_SLVERR);
    add_entry(OP_WR, reg_addr(OFS_SW_CHANGE), 32'hFF, 4'hF, 2'd0, 4'd0, 1'b0, RESP_SLVERR);
    add_entry(OP_RD, reg_addr(OFS_LED_DATA), 32'h0, 4'hF, 2'd0, 4'd0, 1'b0, RESP_OKAY);
    // Long back-pressure on both response channels
    add_entry(OP_WR, reg_addr(OFS_LED_DATA), 32'h0, 4'hF, 2'd1, 4'd8, 1'b1, RESP_OKAY);
    add_entry(OP_RD, reg_addr(OFS_LED_DATA), 32'h0, 4'hF, 2'd0, 4'd8, 1'b0, RESP_OKAY);
  endtask

  // ==========================================================================
  // Main sequence and watchdog
  // ==========================================================================
  initial begin
    entry_t e;
    lcg_state = 32'h7b51_bc87;
    rst      <= 1'b1;
    awvalid  <= 1'b0;
    awaddr   <= '0;
    wvalid   <= 1'b0;
    wdata    <= '0;
    wstrb    <= '0;
    bready   <= 1'b0;
    arvalid  <= 1'b0;
    araddr   <= '0;
    rready   <= 1'b0;
    sw       <= '0;
    exp_resp <= RESP_OKAY;
    fill_table();
    repeat (5) @(posedge clk25);
    rst <= 1'b0;
    for (int i = 0; i < n_ent; i++) begin
      e = tbl[i];
      if (e.rnd) begin
        e.data = next_rand();
      end
      case (e.op)
        OP_WR: begin
          exp_resp <= e.resp;
          write_reg(e.addr, e.data, e.strb, e.order, e.dly);
        end
        OP_RD: begin
          exp_resp <= e.resp;
          read_reg(e.addr, e.dly);
        end
        default: set_switches(e.data[IO_W-1:0]);
      endcase
    end
    // Falling edge so the checker has finished its last rising edge
    repeat (4) @(negedge clk25);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the bus operations did not finish within %0d ns", TIMEOUT_NS);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
source/io_subsys_pkg.sv
source/axil_slave_port.sv
source/io_reg_decoder.sv
source/led_sw_port.sv
source/io_subsys_top.sv
tb/io_subsys_checker.sv
tb/tb_io_subsys.sv

//--- Makefile
TOP := tb_io_subsys

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -f flist.f \
		--top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log
